/* common/rs_cfg.svh */
// reservation station slice configuration
// widths and counts shared by every block of the issue slice

`ifndef RS_CFG_SVH
`define RS_CFG_SVH

// station table
`define RS_ENTRIES    8
`define RS_IDX_WIDTH  3
`define STATUS_WIDTH  3

// tags and data
`define TAG_WIDTH     4
`define TAG_NULL      ({`TAG_WIDTH{1'b0}})
`define DATA_WIDTH    32
`define OP_WIDTH      3

// issue ports, one per execution unit
`define ISSUE_PORTS   2

// cdb producers: unit 0, unit 1, load port
`define CDB_PRODUCERS 3
`define CDB_PTR_WIDTH 2

`endif

/* common/rs_pkg.sv */
// types for the reservation station slice
// station status, opcodes and the packed transfer structs

`default_nettype none

package rs_pkg;

`include "rs_cfg.svh"

   // station state, waiting_a means operand a still pending
   typedef enum logic [`STATUS_WIDTH-1:0]
   {
      rs_empty        = 3'b000,
      rs_waiting_a    = 3'b001,
      rs_waiting_b    = 3'b010,
      rs_waiting_both = 3'b011,
      rs_ready        = 3'b100
   } rs_status_e;

   // integer unit opcodes
   typedef enum logic [`OP_WIDTH-1:0]
   {
      op_add = 3'b000,
      op_sub = 3'b001,
      op_and = 3'b010,
      op_or  = 3'b011,
      op_xor = 3'b100
   } rs_op_e;

   ////////////////////////////////////////////////////////////////////
   // transfer structs
   ////////////////////////////////////////////////////////////////////

   // source operand, value valid only with null tag
   typedef struct packed
   {
      logic [`TAG_WIDTH-1:0]  tag;
      logic [`DATA_WIDTH-1:0] value;
   } operand_t;

   // one instruction into the table
   typedef struct packed
   {
      rs_op_e                op;
      logic [`TAG_WIDTH-1:0] dest;
      operand_t              src_a;
      operand_t              src_b;
   } dispatch_t;

   // one instruction to a unit, both operands resolved
   typedef struct packed
   {
      rs_op_e                 op;
      logic [`TAG_WIDTH-1:0]  dest;
      logic [`DATA_WIDTH-1:0] value_a;
      logic [`DATA_WIDTH-1:0] value_b;
   } issue_t;

   // one result on the cdb, also used by the load return
   typedef struct packed
   {
      logic [`TAG_WIDTH-1:0]  tag;
      logic [`DATA_WIDTH-1:0] value;
   } cdb_t;

endpackage

`default_nettype wire

/* reservation_station/rs_entry.sv */
// single reservation station
// holds one instruction, tracks pending operand tags and snoops the cdb

`timescale 1ns/1ns
`default_nettype none

`include "rs_cfg.svh"

module rs_entry
(
   input  wire logic                clock,
   input  wire logic                reset,
   input  wire logic                fill,
   input  wire rs_pkg::dispatch_t   fill_data,
   input  wire logic                cdb_valid,
   input  wire rs_pkg::cdb_t        cdb,
   input  wire logic                issue_take,
   output rs_pkg::rs_status_e       status,
   output rs_pkg::issue_t           entry_issue
);

   import rs_pkg::*;

   // held instruction
   rs_status_e              status_q;
   rs_op_e                  op_q;
   logic [`TAG_WIDTH-1:0]   dest_q;
   logic [`TAG_WIDTH-1:0]   tag_a_q;
   logic [`TAG_WIDTH-1:0]   tag_b_q;
   logic [`DATA_WIDTH-1:0]  val_a_q;
   logic [`DATA_WIDTH-1:0]  val_b_q;

   // operand source and next state
   operand_t                src_a;
   operand_t                src_b;
   logic                    hit_a;
   logic                    hit_b;
   logic [`TAG_WIDTH-1:0]   tag_a_d;
   logic [`TAG_WIDTH-1:0]   tag_b_d;
   logic [`DATA_WIDTH-1:0]  val_a_d;
   logic [`DATA_WIDTH-1:0]  val_b_d;
   rs_status_e              status_d;

   // on fill the incoming operands are the ones to check against the cdb
   always_comb
   begin
      if (fill)
      begin
         src_a = fill_data.src_a;
         src_b = fill_data.src_b;
      end
      else
      begin
         src_a = '{tag: tag_a_q, value: val_a_q};
         src_b = '{tag: tag_b_q, value: val_b_q};
      end
   end

   // capture: pending tag matches the broadcast
   assign hit_a   = cdb_valid && (src_a.tag != `TAG_NULL) && (src_a.tag == cdb.tag);
   assign hit_b   = cdb_valid && (src_b.tag != `TAG_NULL) && (src_b.tag == cdb.tag);
   assign tag_a_d = hit_a ? `TAG_NULL : src_a.tag;
   assign tag_b_d = hit_b ? `TAG_NULL : src_b.tag;
   assign val_a_d = hit_a ? cdb.value : src_a.value;
   assign val_b_d = hit_b ? cdb.value : src_b.value;

   // status follows the tags still pending
   always_comb
   begin
      if (issue_take)
         status_d = rs_empty;
      else if (fill || (status_q != rs_empty))
      begin
         case ({(tag_a_d != `TAG_NULL), (tag_b_d != `TAG_NULL)})
            2'b00:   status_d = rs_ready;
            2'b10:   status_d = rs_waiting_a;
            2'b01:   status_d = rs_waiting_b;
            default: status_d = rs_waiting_both;
         endcase
      end
      else
         status_d = rs_empty;
   end

   // control state
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         status_q <= rs_empty;
         tag_a_q  <= `TAG_NULL;
         tag_b_q  <= `TAG_NULL;
      end
      else
      begin
         status_q <= status_d;
         tag_a_q  <= tag_a_d;
         tag_b_q  <= tag_b_d;
      end
   end

   // payload
   always_ff @(posedge clock)
   begin
      if (fill)
      begin
         op_q   <= fill_data.op;
         dest_q <= fill_data.dest;
      end
      val_a_q <= val_a_d;
      val_b_q <= val_b_d;
   end

   assign status      = status_q;
   assign entry_issue = '{op: op_q, dest: dest_q, value_a: val_a_q, value_b: val_b_q};

endmodule

`default_nettype wire

/* reservation_station/rs_table.sv */
// reservation station table
// allocates free stations on dispatch and issues ready ones to two units

`timescale 1ns/1ns
`default_nettype none

`include "rs_cfg.svh"

module rs_table
(
   input  wire logic                               clock,
   input  wire logic                               reset,
   input  wire logic                               dispatch_valid,
   input  wire rs_pkg::dispatch_t                  dispatch,
   output logic                                    dispatch_ready,
   input  wire logic                               cdb_valid,
   input  wire rs_pkg::cdb_t                       cdb,
   output logic [`ISSUE_PORTS-1:0]                 issue_valid,
   output rs_pkg::issue_t [`ISSUE_PORTS-1:0]       issue,
   input  wire logic [`ISSUE_PORTS-1:0]            issue_ready
);

   import rs_pkg::*;

   // per station view
   rs_status_e                status      [`RS_ENTRIES];
   issue_t                    entry_issue [`RS_ENTRIES];
   logic [`RS_ENTRIES-1:0]    empty;
   logic [`RS_ENTRIES-1:0]    ready;
   logic [`RS_ENTRIES-1:0]    fill;
   logic [`RS_ENTRIES-1:0]    issue_take;

   // selections
   logic                      free_found;
   logic [`RS_IDX_WIDTH-1:0]  free_idx;
   logic                      found0;
   logic                      found1;
   logic [`RS_IDX_WIDTH-1:0]  sel0;
   logic [`RS_IDX_WIDTH-1:0]  sel1;

   ////////////////////////////////////////////////////////////////////
   // station array
   ////////////////////////////////////////////////////////////////////

   for (genvar g = 0; g < `RS_ENTRIES; g++)
   begin : g_entry
      rs_entry u_rs_entry
      (
         .clock       (clock),
         .reset       (reset),
         .fill        (fill[g]),
         .fill_data   (dispatch),
         .cdb_valid   (cdb_valid),
         .cdb         (cdb),
         .issue_take  (issue_take[g]),
         .status      (status[g]),
         .entry_issue (entry_issue[g])
      );

      assign empty[g] = (status[g] == rs_empty);
      assign ready[g] = (status[g] == rs_ready);

      // only the lowest empty station takes the dispatch
      assign fill[g] = dispatch_valid && free_found && (free_idx == g);

      // freed on the edge its issue transfers
      assign issue_take[g] = (found0 && issue_ready[0] && (sel0 == g))
                          || (found1 && issue_ready[1] && (sel1 == g));
   end

   ////////////////////////////////////////////////////////////////////
   // allocation and ready selection
   ////////////////////////////////////////////////////////////////////

   // lowest empty station
   always_comb
   begin
      free_found = 1'b0;
      free_idx   = '0;
      for (int i = 0; i < `RS_ENTRIES; i++)
      begin
         if (!free_found && empty[i])
         begin
            free_found = 1'b1;
            free_idx   = i[`RS_IDX_WIDTH-1:0];
         end
      end
   end

   // lowest ready goes to unit 0, next one to unit 1
   always_comb
   begin
      found0 = 1'b0;
      found1 = 1'b0;
      sel0   = '0;
      sel1   = '0;
      for (int i = 0; i < `RS_ENTRIES; i++)
      begin
         if (ready[i])
         begin
            if (!found0)
            begin
               found0 = 1'b1;
               sel0   = i[`RS_IDX_WIDTH-1:0];
            end
            else if (!found1)
            begin
               found1 = 1'b1;
               sel1   = i[`RS_IDX_WIDTH-1:0];
            end
         end
      end
   end

   // full table drops ready
   assign dispatch_ready = free_found;

   assign issue_valid = {found1, found0};
   assign issue[0]    = entry_issue[sel0];
   assign issue[1]    = entry_issue[sel1];

endmodule

`default_nettype wire

/* source/cdb_arbiter.sv */
// round-robin cdb arbiter
// grants one of three producers per cycle and drives the broadcast

`timescale 1ns/1ns
`default_nettype none

`include "rs_cfg.svh"

module cdb_arbiter
(
   input  wire logic                                clock,
   input  wire logic                                reset,
   input  wire logic [`CDB_PRODUCERS-1:0]           request,
   input  wire rs_pkg::cdb_t [`CDB_PRODUCERS-1:0]   result,
   output logic [`CDB_PRODUCERS-1:0]                grant,
   output logic                                     cdb_valid,
   output rs_pkg::cdb_t                             cdb
);

   import rs_pkg::*;

   // highest priority requester this cycle
   logic [`CDB_PTR_WIDTH-1:0]  ptr_q;
   logic [`CDB_PTR_WIDTH-1:0]  winner;
   logic                       found;
   int                         cand;

   // scan from the pointer, wrapping once
   always_comb
   begin
      found  = 1'b0;
      winner = ptr_q;
      grant  = '0;
      cdb    = '0;
      cand   = 0;
      for (int k = 0; k < `CDB_PRODUCERS; k++)
      begin
         cand = int'(ptr_q) + k;
         if (cand >= `CDB_PRODUCERS)
            cand = cand - `CDB_PRODUCERS;
         if (!found && request[cand])
         begin
            found  = 1'b1;
            winner = cand[`CDB_PTR_WIDTH-1:0];
         end
      end
      if (found)
      begin
         grant[winner] = 1'b1;
         cdb           = result[winner];
      end
   end

   assign cdb_valid = found;

   // pointer moves past the last winner
   always_ff @(posedge clock)
   begin
      if (reset)
         ptr_q <= '0;
      else if (found)
         ptr_q <= (winner == `CDB_PRODUCERS - 1) ? '0 : winner + 1'b1;
   end

endmodule

`default_nettype wire

/* source/exec_unit.sv */
// two-stage integer execution unit
// registers operands, computes, then holds the result until the cdb grant

`timescale 1ns/1ns
`default_nettype none

`include "rs_cfg.svh"

module exec_unit
(
   input  wire logic             clock,
   input  wire logic             reset,
   input  wire logic             issue_valid,
   input  wire rs_pkg::issue_t   issue,
   output logic                  issue_ready,
   output logic                  cdb_request,
   output rs_pkg::cdb_t          result,
   input  wire logic             cdb_grant
);

   import rs_pkg::*;

   logic                    s1_valid;
   issue_t                  s1_q;
   logic                    s2_valid;
   cdb_t                    s2_q;
   logic                    issue_fire;
   logic                    advance;
   logic [`DATA_WIDTH-1:0]  alu_out;

   // stage two blocked while its result waits for a grant
   assign issue_ready = !s2_valid || cdb_grant;
   assign issue_fire  = issue_valid && issue_ready;
   assign advance     = s1_valid && issue_ready;

   // alu, wraparound arithmetic
   always_comb
   begin
      case (s1_q.op)
         op_add:  alu_out = s1_q.value_a + s1_q.value_b;
         op_sub:  alu_out = s1_q.value_a - s1_q.value_b;
         op_and:  alu_out = s1_q.value_a & s1_q.value_b;
         op_or:   alu_out = s1_q.value_a | s1_q.value_b;
         op_xor:  alu_out = s1_q.value_a ^ s1_q.value_b;
         default: alu_out = '0;
      endcase
   end

   // pipeline occupancy
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end
      else
      begin
         if (issue_fire)
            s1_valid <= 1'b1;
         else if (advance)
            s1_valid <= 1'b0;

         if (advance)
            s2_valid <= 1'b1;
         else if (cdb_grant)
            s2_valid <= 1'b0;
      end
   end

   // stage payloads, stage two held until granted
   always_ff @(posedge clock)
   begin
      if (issue_fire)
         s1_q <= issue;
      if (advance)
         s2_q <= '{tag: s1_q.dest, value: alu_out};
   end

   assign cdb_request = s2_valid;
   assign result      = s2_q;

endmodule

`default_nettype wire

/* source/rs_core.sv */
// out-of-order issue slice top level
// station table, two execution units and a load port sharing one cdb

`timescale 1ns/1ns
`default_nettype none

`include "rs_cfg.svh"

module rs_core
(
   input  wire logic                clock,
   input  wire logic                reset,
   input  wire logic                dispatch_valid,
   input  wire rs_pkg::dispatch_t   dispatch,
   output logic                     dispatch_ready,
   input  wire logic                load_valid,
   input  wire rs_pkg::cdb_t        load,
   output logic                     load_ready,
   output logic                     cdb_valid,
   output rs_pkg::cdb_t             cdb
);

   import rs_pkg::*;

   // table to units
   logic [`ISSUE_PORTS-1:0]          issue_valid;
   issue_t [`ISSUE_PORTS-1:0]        issue;
   logic [`ISSUE_PORTS-1:0]          issue_ready;

   // producers to arbiter, index 2 is the load port
   logic [`CDB_PRODUCERS-1:0]        cdb_request;
   cdb_t [`CDB_PRODUCERS-1:0]        cdb_result;
   logic [`CDB_PRODUCERS-1:0]        cdb_grant;

   rs_table u_rs_table
   (
      .clock          (clock),
      .reset          (reset),
      .dispatch_valid (dispatch_valid),
      .dispatch       (dispatch),
      .dispatch_ready (dispatch_ready),
      .cdb_valid      (cdb_valid),
      .cdb            (cdb),
      .issue_valid    (issue_valid),
      .issue          (issue),
      .issue_ready    (issue_ready)
   );

   exec_unit u_exec_0
   (
      .clock       (clock),
      .reset       (reset),
      .issue_valid (issue_valid[0]),
      .issue       (issue[0]),
      .issue_ready (issue_ready[0]),
      .cdb_request (cdb_request[0]),
      .result      (cdb_result[0]),
      .cdb_grant   (cdb_grant[0])
   );

   exec_unit u_exec_1
   (
      .clock       (clock),
      .reset       (reset),
      .issue_valid (issue_valid[1]),
      .issue       (issue[1]),
      .issue_ready (issue_ready[1]),
      .cdb_request (cdb_request[1]),
      .result      (cdb_result[1]),
      .cdb_grant   (cdb_grant[1])
   );

   // load return competes as the third producer
   assign cdb_request[2] = load_valid;
   assign cdb_result[2]  = load;
   assign load_ready     = cdb_grant[2];

   cdb_arbiter u_cdb_arbiter
   (
      .clock     (clock),
      .reset     (reset),
      .request   (cdb_request),
      .result    (cdb_result),
      .grant     (cdb_grant),
      .cdb_valid (cdb_valid),
      .cdb       (cdb)
   );

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/rs_pkg.sv
reservation_station/rs_entry.sv
reservation_station/rs_table.sv
source/exec_unit.sv
source/cdb_arbiter.sv
source/rs_core.sv
testbench/rs_core_checker.sv
testbench/rs_core_tb.sv

/* testbench/rs_core_checker.sv */
// cdb arbiter and broadcast assertions
// bound into the slice top level

`timescale 1ns/1ns
`default_nettype none

`include "rs_cfg.svh"

module rs_core_checker
(
   input wire logic                               clock,
   input wire logic                               reset,
   input wire logic [`CDB_PRODUCERS-1:0]          request,
   input wire rs_pkg::cdb_t [`CDB_PRODUCERS-1:0]  result,
   input wire logic [`CDB_PRODUCERS-1:0]          grant,
   input wire logic                               cdb_valid,
   input wire rs_pkg::cdb_t                       cdb
);

   import rs_pkg::*;

   // count of failed assertions
   int failures = 0;

   a_grant_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(grant))
   else
   begin
      failures++;
      $error("cdb grant is not one-hot");
   end

   a_grant_requested: assert property (@(posedge clock) disable iff (reset)
      (grant & ~request) == '0)
   else
   begin
      failures++;
      $error("cdb grant without a request");
   end

   // null tag never broadcast
   a_cdb_tag: assert property (@(posedge clock) disable iff (reset)
      cdb_valid |-> cdb.tag != '0)
   else
   begin
      failures++;
      $error("cdb valid with the null tag");
   end

   // waiting producer holds request and result
   for (genvar g = 0; g < `CDB_PRODUCERS; g++)
   begin : g_hold
      a_hold_stable: assert property (@(posedge clock) disable iff (reset)
         request[g] && !grant[g] |=> request[g] && $stable(result[g]))
      else
      begin
         failures++;
         $error("producer %0d changed its request before the grant", g);
      end
   end

endmodule

bind rs_core rs_core_checker u_rs_core_checker
(
   .clock       (clock),
   .reset       (reset),
   .request     (cdb_request),
   .result      (cdb_result),
   .grant       (cdb_grant),
   .cdb_valid   (cdb_valid),
   .cdb         (cdb)
);

`default_nettype wire

/* testbench/rs_core_tb.sv */
// testbench for the out-of-order issue slice
// directed tests, results gathered per tag off the cdb and checked against a model

`timescale 1ns/1ns
`default_nettype none

`include "rs_cfg.svh"

module rs_core_tb;

   import rs_pkg::*;

   localparam int timeout_cycles = 300;
   localparam int tag_count      = 1 << `TAG_WIDTH;

   logic        clock;
   logic        reset;
   logic        dispatch_valid;
   dispatch_t   dispatch;
   logic        dispatch_ready;
   logic        load_valid;
   cdb_t        load;
   logic        load_ready;
   logic        cdb_valid;
   cdb_t        cdb;

   // scoreboard, one slot per tag
   cdb_t        exp_result  [tag_count];
   logic        exp_valid   [tag_count];
   cdb_t        seen_result [tag_count];
   int          seen_count  [tag_count];

   rs_core u_rs_core (.*);

   initial
   begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   // every broadcast lands in its tag slot, sampled mid-cycle
   always @(negedge clock)
   begin
      if (!reset && cdb_valid)
      begin
         seen_count[cdb.tag]  = seen_count[cdb.tag] + 1;
         seen_result[cdb.tag] = cdb;
      end
   end

   // first assertion failure ends the run
   always @(negedge clock)
   begin
      if (u_rs_core.u_rs_core_checker.failures != 0)
      begin
         $display("assertion failure reported by the bound checker");
         abort_run();
      end
   end

   //////////////////////////////////////////////////////////////////////
   // reporting and compare
   //////////////////////////////////////////////////////////////////////

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_cdb(input string name, input cdb_t expected, input cdb_t actual);
      if (actual !== expected)
      begin
         $display("Fail %s expected tag %0d value %h actual tag %0d value %h",
                  name, expected.tag, expected.value, actual.tag, actual.value);
         abort_run();
      end
   endtask

   task automatic check_status(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         $display("Fail %s expected %b actual %b", name, expected, actual);
         abort_run();
      end
   endtask

   // reference alu, wraparound arithmetic
   function automatic logic [`DATA_WIDTH-1:0] model_result(input rs_op_e op,
      input logic [`DATA_WIDTH-1:0] a, input logic [`DATA_WIDTH-1:0] b);
      case (op)
         op_add:  return a + b;
         op_sub:  return a - b;
         op_and:  return a & b;
         op_or:   return a | b;
         op_xor:  return a ^ b;
         default: return 'x;
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // drivers and waits
   //////////////////////////////////////////////////////////////////////

   task automatic clear_results();
      for (int t = 0; t < tag_count; t++)
      begin
         exp_valid[t]  = 1'b0;
         seen_count[t] = 0;
      end
   endtask

   task automatic expect_result(input logic [`TAG_WIDTH-1:0] tag,
                                input logic [`DATA_WIDTH-1:0] value);
      exp_result[tag] = cdb_t'{tag: tag, value: value};
      exp_valid[tag]  = 1'b1;
   endtask

   // held until the table takes it
   task automatic send_dispatch(input rs_op_e op, input logic [`TAG_WIDTH-1:0] dest,
                                input operand_t src_a, input operand_t src_b);
      int cycles = 0;
      @(posedge clock);
      dispatch_valid <= 1'b1;
      dispatch       <= dispatch_t'{op: op, dest: dest, src_a: src_a, src_b: src_b};
      do
      begin
         @(posedge clock);
         cycles++;
         if (cycles > timeout_cycles)
         begin
            $display("dispatch of tag %0d was never accepted", dest);
            abort_run();
         end
      end while (!dispatch_ready);
      dispatch_valid <= 1'b0;
   endtask

   // load return, held until granted the cdb
   task automatic send_load(input logic [`TAG_WIDTH-1:0] tag,
                            input logic [`DATA_WIDTH-1:0] value);
      int cycles = 0;
      @(posedge clock);
      load_valid <= 1'b1;
      load       <= cdb_t'{tag: tag, value: value};
      do
      begin
         @(posedge clock);
         cycles++;
         if (cycles > timeout_cycles)
         begin
            $display("load return of tag %0d never got the cdb", tag);
            abort_run();
         end
      end while (!load_ready);
      load_valid <= 1'b0;
   endtask

   task automatic wait_dispatch_ready(input logic level);
      int cycles = 0;
      while (dispatch_ready !== level)
      begin
         @(posedge clock);
         cycles++;
         if (cycles > timeout_cycles)
         begin
            $display("dispatch_ready did not reach %b in time", level);
            abort_run();
         end
      end
   endtask

   // wait for every expected tag, then look for extras or repeats
   task automatic verify_results(input string name);
      int cycles = 0;
      bit all_seen = 1'b0;
      while (!all_seen)
      begin
         @(posedge clock);
         cycles++;
         all_seen = 1'b1;
         for (int t = 0; t < tag_count; t++)
         begin
            if (exp_valid[t] && seen_count[t] == 0)
               all_seen = 1'b0;
         end
         if (cycles > timeout_cycles)
         begin
            $display("%s: results still missing from the cdb after %0d cycles", name, cycles);
            abort_run();
         end
      end
      repeat (10) @(posedge clock);
      for (int t = 0; t < tag_count; t++)
      begin
         if (seen_count[t] != (exp_valid[t] ? 1 : 0))
         begin
            $display("%s: tag %0d appeared %0d times on the cdb", name, t, seen_count[t]);
            abort_run();
         end
         if (exp_valid[t])
            check_cdb(name, exp_result[t], seen_result[t]);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // directed tests
   //////////////////////////////////////////////////////////////////////

   task automatic test_reset_idle();
      repeat (20)
      begin
         @(posedge clock);
         check_status("reset_idle dispatch_ready", 1'b1, dispatch_ready);
         check_status("reset_idle cdb_valid", 1'b0, cdb_valid);
         check_status("reset_idle load_ready", 1'b0, load_ready);
      end
   endtask

   // one independent dispatch per opcode, sub wraps on k = 1
   task automatic test_opcodes();
      logic [`DATA_WIDTH-1:0] a;
      logic [`DATA_WIDTH-1:0] b;
      clear_results();
      for (int k = 0; k < 5; k++)
      begin
         a = 32'h0000_1234 + k * 32'h1111_0000;
         b = 32'h8ff0_4321 ^ k;
         expect_result(`TAG_WIDTH'(k + 1), model_result(rs_op_e'(k), a, b));
         send_dispatch(rs_op_e'(k), `TAG_WIDTH'(k + 1), operand_t'{tag: '0, value: a},
                       operand_t'{tag: '0, value: b});
      end
      verify_results("opcodes");
   endtask

   // each link takes operand a from the previous dest tag
   task automatic test_chain();
      logic [`DATA_WIDTH-1:0] prev;
      logic [`DATA_WIDTH-1:0] other;
      operand_t               src_a;
      rs_op_e                 op;
      clear_results();
      prev = 32'h0000_1000;
      for (int k = 1; k <= 6; k++)
      begin
         op    = rs_op_e'(k % 5);
         other = 32'h10 * k + 3;
         if (k == 1)
            src_a = operand_t'{tag: '0, value: prev};
         else
            src_a = operand_t'{tag: `TAG_WIDTH'(k - 1), value: '0};
         prev = model_result(op, prev, other);
         expect_result(`TAG_WIDTH'(k), prev);
         send_dispatch(op, `TAG_WIDTH'(k), src_a, operand_t'{tag: '0, value: other});
      end
      verify_results("chain");
   endtask

   // fill the table behind tag 15, then release it with a load
   task automatic test_wait_on_load();
      logic [`DATA_WIDTH-1:0] load_value;
      logic [`DATA_WIDTH-1:0] b;
      operand_t               src_b;
      clear_results();
      load_value = 32'h1234_5678;
      for (int i = 1; i <= 8; i++)
      begin
         b = 32'h111 * i;
         // even slots wait on both operands
         if (i % 2 == 0)
            src_b = operand_t'{tag: 4'd15, value: '0};
         else
            src_b = operand_t'{tag: '0, value: b};
         expect_result(`TAG_WIDTH'(i), model_result(rs_op_e'(i % 5), load_value,
                       (i % 2 == 0) ? load_value : b));
         send_dispatch(rs_op_e'(i % 5), `TAG_WIDTH'(i), operand_t'{tag: 4'd15, value: '0}, src_b);
      end
      wait_dispatch_ready(1'b0);
      // parked stations stay put until the load arrives
      repeat (5)
      begin
         @(posedge clock);
         check_status("wait_on_load held full", 1'b0, dispatch_ready);
         check_status("wait_on_load no early result", 1'b0, cdb_valid);
      end
      expect_result(4'd15, load_value);
      send_load(4'd15, load_value);
      wait_dispatch_ready(1'b1);
      verify_results("wait_on_load");
   endtask

   // random ops against concurrent load returns, three rounds of tags
   task automatic test_contention();
      for (int round = 0; round < 3; round++)
      begin
         clear_results();
         fork
            begin : ops
               logic [`DATA_WIDTH-1:0] a;
               logic [`DATA_WIDTH-1:0] b;
               rs_op_e                 op;
               for (int k = 1; k <= 10; k++)
               begin
                  a  = $urandom();
                  b  = $urandom();
                  op = rs_op_e'($urandom_range(4, 0));
                  expect_result(`TAG_WIDTH'(k), model_result(op, a, b));
                  send_dispatch(op, `TAG_WIDTH'(k), operand_t'{tag: '0, value: a},
                                operand_t'{tag: '0, value: b});
               end
            end
            begin : loads
               logic [`DATA_WIDTH-1:0] v;
               for (int k = 11; k <= 13; k++)
               begin
                  v = $urandom();
                  repeat ($urandom_range(3, 0)) @(posedge clock);
                  expect_result(`TAG_WIDTH'(k), v);
                  send_load(`TAG_WIDTH'(k), v);
               end
            end
         join
         verify_results("contention");
      end
   endtask

   initial
   begin
      void'($urandom(32'h811c_e785));
      reset          = 1'b1;
      dispatch_valid = 1'b0;
      dispatch       = '0;
      load_valid     = 1'b0;
      load           = '0;
      clear_results();
      repeat (10) @(posedge clock);
      reset <= 1'b0;
      test_reset_idle();
      test_opcodes();
      test_chain();
      test_wait_on_load();
      test_contention();
      if (u_rs_core.u_rs_core_checker.failures != 0)
      begin
         $display("%0d assertion failures in the bound checker",
                  u_rs_core.u_rs_core_checker.failures);
         abort_run();
      end
      else
      begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

endmodule

`default_nettype wire
